//--- Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module uart_rx_tb \
		-f uart_rx_top.f -o Vuart_rx_tb
	./obj_dir/Vuart_rx_tb | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- uart_rx_top.f
verilog/uart_rx_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_rx_channel.sv
verilog/uart_rx_drain.sv
verilog/uart_rx_top.sv
verif/uart_rx_props.sv
verif/uart_rx_tb.sv

//--- verif/uart_rx_props.sv
`default_nettype none

module uart_rx_props (
    input logic                                     clk,
    input logic                                     reset,
    input logic                                     out_req,
    input logic                                     out_ack,
    input logic [uart_rx_pkg::num_channels-1:0]     take,
    input logic [7:0]                               out_data,
    input logic [uart_rx_pkg::channel_idx_bits-1:0] out_channel
);

    // Request drops only in answer to an acknowledge
    assert property (@(posedge clk) disable iff (reset)
        $fell(out_req) |-> $past(out_ack))
        else $error("out_req fell without out_ack");

    assert property (@(posedge clk) disable iff (reset)
        $rose(out_req) |-> !$past(out_ack))
        else $error("out_req rose while out_ack was high");

    assert property (@(posedge clk) disable iff (reset)
        $onehot0(take))
        else $error("more than one take pulse at once");

    // Result held steady for the whole request phase
    assert property (@(posedge clk) disable iff (reset)
        out_req && $past(out_req) |-> $stable(out_data) && $stable(out_channel))
        else $error("out_data or out_channel changed while out_req was high");

endmodule

bind uart_rx_drain uart_rx_props i_props (
    .clk         (clk),
    .reset       (reset),
    .out_req     (out_req),
    .out_ack     (out_ack),
    .take        (take),
    .out_data    (out_data),
    .out_channel (out_channel)
);

`default_nettype wire

//--- verif/uart_rx_tb.sv
`default_nettype none

module uart_rx_tb;

    import uart_rx_pkg::*;

    logic                          clk;
    logic                          reset;
    logic [2:0]                    baud_select;
    logic [num_channels-1:0]       rx_en;
    logic [num_channels-1:0]       rxd;
    logic                          out_req;
    logic                          out_ack;
    logic [7:0]                    out_data;
    logic [channel_idx_bits-1:0]   out_channel;
    rx_status_t                    out_status;

    logic [15:0] lfsr = 16'd35563;
    int          last_ch;        // Channel the drain served most recently
    int          checks;
    int          errors;
    int          errors_before;  // Error count when the current test began
    int          tests;

    uart_rx_top i_uart_rx_top (
        .clk         (clk),
        .reset       (reset),
        .baud_select (baud_select),
        .rx_en       (rx_en),
        .rxd         (rxd),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_status  (out_status)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic int rand_bits(input int n);
        int   r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: out_data is %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_channel(input logic [channel_idx_bits-1:0] got,
                                 input logic [channel_idx_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: out_channel is %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input rx_status_t got, input rx_status_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: out_status is %s, expected %s", $time, got.name(), exp.name());
            errors++;
        end
    endtask

    // Bit 0 is the start bit, then data LSB first, even parity and stop
    function automatic logic [data_bits+2:0] build_frame(input logic [7:0] value,
                                                         input logic bad_parity,
                                                         input logic low_stop);
        return {~low_stop, (^value) ^ bad_parity, value, 1'b0};
    endfunction

    task automatic send_frames(input logic [num_channels-1:0] mask,
                               input logic [data_bits+2:0] frames [num_channels],
                               input int glitch_bit);
        int div;
        div = int'(baud_divisors[baud_select]);  // clk cycles per sample
        for (int b = 0; b < data_bits + 3; b++) begin
            for (int s = 0; s < oversample * div; s++) begin
                @(negedge clk);
                for (int ch = 0; ch < num_channels; ch++) begin
                    if (mask[ch]) begin
                        // Glitch inverts sample 8 of the chosen bit
                        rxd[ch] = frames[ch][b] ^ (b == glitch_bit && s / div == oversample / 2);
                    end
                end
            end
        end
        @(negedge clk);
        rxd = '1;
        repeat (2 * oversample * div) @(negedge clk);  // Idle gap
    endtask

    task automatic send_one(input int ch, input logic [7:0] value, input logic bad_parity,
                            input logic low_stop, input int glitch_bit);
        logic [data_bits+2:0]    frames [num_channels];
        logic [num_channels-1:0] mask;
        frames     = '{default: '1};
        frames[ch] = build_frame(value, bad_parity, low_stop);
        mask       = '0;
        mask[ch]   = 1'b1;
        send_frames(mask, frames, glitch_bit);
    endtask

    task automatic wait_level(input logic level, input int limit, output bit ok);
        int n;
        n = 0;
        while (out_req !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        ok = (out_req === level);
    endtask

    // Plays the outside end of the four-phase handshake
    task automatic receive_check(input int exp_ch, input logic [7:0] exp_byte,
                                 input rx_status_t exp_status, input int delay_bits);
        bit ok;
        wait_level(1'b1, 4000, ok);
        if (!ok) begin
            $display("Timed out at %0t waiting for out_req from channel %0d", $time, exp_ch);
            errors++;
        end else begin
            check_channel(out_channel, channel_idx_bits'(exp_ch));
            check_byte(out_data, exp_byte);
            check_status(out_status, exp_status);
            out_ack = 1'b1;
            repeat (rand_bits(delay_bits)) @(negedge clk);  // Pending results wait meanwhile
            wait_level(1'b0, 100, ok);
            if (!ok) begin
                $display("Timed out at %0t: out_req did not drop after out_ack", $time);
                errors++;
            end
            out_ack = 1'b0;
            last_ch = exp_ch;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        bit seen;
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            seen = seen | out_req;
        end
        checks++;
        if (seen) begin
            $display("FAIL %0t: out_req rose when no result was expected", $time);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d, %s: %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic clean_frames();
        logic [7:0] value;
        for (int ch = 0; ch < num_channels; ch++) begin
            value = 8'(rand_bits(8));
            send_one(ch, value, 1'b0, 1'b0, -1);
            receive_check(ch, value, rx_ok, 3);
        end
        end_test("clean frames on each channel");
    endtask

    task automatic parity_error();
        logic [7:0] value;
        value = 8'(rand_bits(8));
        send_one(2, value, 1'b1, 1'b0, -1);
        receive_check(2, value, rx_parity_err, 3);
        end_test("inverted parity bit");
    endtask

    task automatic frame_errors();
        logic [7:0] value;
        value = 8'(rand_bits(8));
        send_one(1, value, 1'b0, 1'b1, -1);  // Low stop bit
        receive_check(1, value, rx_frame_err, 3);
        value = 8'(rand_bits(8));
        send_one(3, value, 1'b0, 1'b0, 4);  // Glitch in data bit 3
        receive_check(3, value, rx_frame_err, 3);
        end_test("low stop bit and split vote");
    endtask

    task automatic all_channels();
        logic [7:0]           values [num_channels];
        logic [data_bits+2:0] frames [num_channels];
        int                   exp_ch;
        for (int ch = 0; ch < num_channels; ch++) begin
            values[ch] = 8'(rand_bits(8));
            frames[ch] = build_frame(values[ch], 1'b0, 1'b0);
        end
        send_frames('1, frames, -1);
        exp_ch = last_ch;
        for (int k = 0; k < num_channels; k++) begin
            exp_ch = (exp_ch + 1) % num_channels;  // Round robin past the last served
            receive_check(exp_ch, values[exp_ch], rx_ok, 6);
        end
        expect_quiet(500);  // Nothing delivered twice
        end_test("all channels at once");
    endtask

    task automatic disabled_channel();
        logic [7:0] value;
        value    = 8'(rand_bits(8));
        rx_en[0] = 1'b0;
        send_one(0, value, 1'b0, 1'b0, -1);
        expect_quiet(2 * (data_bits + 3) * oversample * int'(baud_divisors[0]));
        rx_en[0]    = 1'b1;
        baud_select = 3'd1;
        repeat (4) @(negedge clk);
        send_one(0, value, 1'b0, 1'b0, -1);
        receive_check(0, value, rx_ok, 3);
        end_test("disabled channel, then baud_select 1");
    endtask

    initial begin
        reset         = 1'b1;
        baud_select   = 3'd0;
        rx_en         = '1;
        rxd           = '1;  // Idle lines
        out_ack       = 1'b0;
        checks        = 0;
        errors        = 0;
        errors_before = 0;
        tests         = 0;
        last_ch       = num_channels - 1;  // First search starts at channel 0
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);

        clean_frames();
        parity_error();
        frame_errors();
        all_channels();
        disabled_channel();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/uart_baud_gen.sv
`default_nettype none

module uart_baud_gen (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] baud_select,
    output logic       sample_tick
);

    import uart_rx_pkg::*;

    logic [divisor_bits-1:0] count;
    logic [divisor_bits-1:0] reload;
    logic [2:0]              select_q;  // Last seen baud_select

    assign reload = baud_divisors[baud_select] - 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count       <= '0;
            select_q    <= 3'd0;
            sample_tick <= 1'b0;
        end else begin
            select_q <= baud_select;
            if (baud_select != select_q) begin
                // Rate changed, start a fresh period
                count       <= reload;
                sample_tick <= 1'b0;
            end else if (count == '0) begin
                count       <= reload;
                sample_tick <= 1'b1;
            end else begin
                count       <= count - 1'b1;
                sample_tick <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_rx_channel.sv
`default_nettype none

module uart_rx_channel (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rx_en,
    input  logic                    rxd,
    input  logic                    sample_tick,
    input  logic                    take,
    output logic                    valid,
    output logic [7:0]              data,
    output uart_rx_pkg::rx_status_t status
);

    import uart_rx_pkg::*;

    typedef logic [$clog2(oversample)-1:0] sample_cnt_t;
    typedef logic [$clog2(data_bits)-1:0]  bit_cnt_t;

    logic [1:0]           sync;        // Two-flop synchronizer
    logic                 rxd_s;
    logic [1:0]           hist;        // Previous two samples
    sample_cnt_t          sample_cnt;  // Sample index within the bit
    bit_cnt_t             bit_cnt;
    logic [data_bits-1:0] shreg;
    logic                 noisy;       // Some vote was split
    logic                 parity_err;
    logic                 vote_now;
    logic                 vote;
    logic                 unanimous;
    rx_state_t            state;

    assign rxd_s = sync[1];

    // Window is samples 7, 8 and 9, resolved on the tick of sample 9
    assign vote_now  = sample_tick && (sample_cnt == sample_cnt_t'(oversample / 2 + 1));
    assign vote      = (hist[1] & hist[0]) | (hist[1] & rxd_s) | (hist[0] & rxd_s);
    assign unanimous = (hist[1] & hist[0] & rxd_s) | ~(hist[1] | hist[0] | rxd_s);

    assign valid = (state == st_hold);
    assign data  = shreg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync       <= 2'b11;
            hist       <= 2'b11;
            sample_cnt <= '0;
            bit_cnt    <= '0;
            noisy      <= 1'b0;
            parity_err <= 1'b0;
            state      <= st_idle;
        end else begin
            sync <= {sync[0], rxd};
            if (sample_tick) begin
                hist       <= {hist[0], rxd_s};
                sample_cnt <= sample_cnt + 1'b1;
            end

            if (vote_now && state inside {st_start, st_data, st_parity, st_stop}) begin
                noisy <= noisy | ~unanimous;
            end

            case (state)
                st_idle: begin
                    if (rx_en && sample_tick && !rxd_s) begin
                        // This zero is sample 0 of the start bit
                        sample_cnt <= sample_cnt_t'(1);
                        noisy      <= 1'b0;
                        parity_err <= 1'b0;
                        state      <= st_start;
                    end
                end
                st_start: begin
                    if (vote_now) begin
                        if (vote) begin
                            state <= st_idle;  // False start
                        end else begin
                            bit_cnt <= '0;
                            state   <= st_data;
                        end
                    end
                end
                st_data: begin
                    if (vote_now) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_cnt_t'(data_bits - 1)) begin
                            state <= st_parity;
                        end
                    end
                end
                st_parity: begin
                    if (vote_now) begin
                        parity_err <= (vote != ^shreg);  // Even parity
                        state      <= st_stop;
                    end
                end
                st_stop: begin
                    if (vote_now) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (take) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            // Disable drops a frame in flight but keeps a held result
            if (!rx_en && state != st_hold) begin
                state <= st_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && vote_now) begin
            shreg <= {vote, shreg[data_bits-1:1]};  // LSB arrives first
        end
        if (state == st_stop && vote_now) begin
            if (!vote || noisy || !unanimous) begin
                status <= rx_frame_err;
            end else if (parity_err) begin
                status <= rx_parity_err;
            end else begin
                status <= rx_ok;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_rx_drain.sv
`default_nettype none

module uart_rx_drain (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [uart_rx_pkg::num_channels-1:0]         valid,
    input  logic [7:0]                                   data [uart_rx_pkg::num_channels],
    input  uart_rx_pkg::rx_status_t                      status [uart_rx_pkg::num_channels],
    output logic [uart_rx_pkg::num_channels-1:0]         take,
    output logic                                         out_req,
    input  logic                                         out_ack,
    output logic [7:0]                                   out_data,
    output logic [uart_rx_pkg::channel_idx_bits-1:0]     out_channel,
    output uart_rx_pkg::rx_status_t                      out_status
);

    import uart_rx_pkg::*;

    drain_state_t                state;
    logic [channel_idx_bits-1:0] last;   // Channel served most recently
    logic [channel_idx_bits-1:0] pick;
    logic                        found;

    // Round-robin search starting one past the last channel served
    always_comb begin
        logic [channel_idx_bits-1:0] idx;
        found = 1'b0;
        pick  = last;
        for (int k = 1; k <= num_channels; k++) begin
            idx = last + channel_idx_bits'(k);
            if (!found && valid[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= dr_scan;
            out_req <= 1'b0;
            take    <= '0;
            last    <= channel_idx_bits'(num_channels - 1);  // First search starts at 0
        end else begin
            take <= '0;
            case (state)
                dr_scan: begin
                    if (found && !out_ack) begin
                        out_req <= 1'b1;
                        state   <= dr_req;
                    end
                end
                dr_req: begin
                    if (out_ack) begin
                        out_req           <= 1'b0;
                        take[out_channel] <= 1'b1;  // Release the channel
                        last              <= out_channel;
                        state             <= dr_wait_low;
                    end
                end
                dr_wait_low: begin
                    if (!out_ack) begin
                        state <= dr_scan;
                    end
                end
                default: state <= dr_scan;
            endcase
        end
    end

    // Result is captured with the rise of out_req
    always_ff @(posedge clk) begin
        if (state == dr_scan && found && !out_ack) begin
            out_data    <= data[pick];
            out_channel <= pick;
            out_status  <= status[pick];
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

    localparam int num_channels     = 4;
    localparam int channel_idx_bits = 2;

    // Frame shape: start, 8 data LSB first, even parity, stop
    localparam int oversample = 16;  // Sample ticks per bit
    localparam int data_bits  = 8;

    localparam int divisor_bits = 16;

    // clk cycles per sample tick, indexed by baud_select
    // Entries 0 and 1 keep simulation short, the rest assume a 25 MHz clk
    localparam logic [divisor_bits-1:0] baud_divisors [8] = '{
        16'd1,
        16'd3,
        16'd14,   // 115200
        16'd27,   // 57600
        16'd41,   // 38400
        16'd81,   // 19200
        16'd163,  // 9600
        16'd326   // 4800
    };

    typedef enum logic [1:0] {
        rx_ok,
        rx_parity_err,
        rx_frame_err
    } rx_status_t;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop,
        st_hold
    } rx_state_t;

    typedef enum logic [1:0] {
        dr_scan,
        dr_req,
        dr_wait_low
    } drain_state_t;

endpackage

`default_nettype wire

//--- verilog/uart_rx_top.sv
`default_nettype none

module uart_rx_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [2:0]                               baud_select,
    input  logic [uart_rx_pkg::num_channels-1:0]     rx_en,
    input  logic [uart_rx_pkg::num_channels-1:0]     rxd,
    output logic                                     out_req,
    input  logic                                     out_ack,
    output logic [7:0]                               out_data,
    output logic [uart_rx_pkg::channel_idx_bits-1:0] out_channel,
    output uart_rx_pkg::rx_status_t                  out_status
);

    import uart_rx_pkg::*;

    logic                    sample_tick;  // Shared by all channels
    logic [num_channels-1:0] valid;
    logic [num_channels-1:0] take;
    logic [7:0]              data [num_channels];
    rx_status_t              status [num_channels];

    uart_baud_gen i_baud_gen (
        .clk         (clk),
        .reset       (reset),
        .baud_select (baud_select),
        .sample_tick (sample_tick)
    );

    for (genvar i = 0; i < num_channels; i++) begin : g_channel
        uart_rx_channel i_channel (
            .clk         (clk),
            .reset       (reset),
            .rx_en       (rx_en[i]),
            .rxd         (rxd[i]),
            .sample_tick (sample_tick),
            .take        (take[i]),
            .valid       (valid[i]),
            .data        (data[i]),
            .status      (status[i])
        );
    end

    uart_rx_drain i_drain (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .data        (data),
        .status      (status),
        .take        (take),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_status  (out_status)
    );

endmodule

`default_nettype wire
